/* rtl/ipv4_fwd_pkg.sv */
////////////////////
// Shared IPv4 header sizes and types for the TTL forwarding stage
// Imported by every RTL block and by the testbench
////////////////////
`default_nettype none

package ipv4_fwd_pkg;

    ////////////////////
    // Header sizes

    localparam int IPV4_HDR_BYTES = 20;
    // 16-bit words covered by the header checksum
    localparam int IPV4_HDR_WORDS = IPV4_HDR_BYTES / 2;
    localparam int IPV4_HDR_BITS  = IPV4_HDR_BYTES * 8;

    ////////////////////
    // Types

    // Ones'-complement checksum value
    typedef logic [15:0] csum_t;

    // Field view, in wire order, version in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        csum_t       hdr_chk;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_hdr_fields_t;

    // Same 160 bits seen as fields or as checksum words
    // Word 0 is the first on the wire, so TTL/protocol is word 4
    typedef union packed {
        ipv4_hdr_fields_t                fields;
        logic [0:IPV4_HDR_WORDS-1][15:0] words;
    } ipv4_hdr_t;

endpackage

`default_nettype wire

/* rtl/ipv4_stage_if.sv */
////////////////////
// Stage results handed from the checksum and TTL blocks to the decision stage
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface ipv4_stage_if
    import ipv4_fwd_pkg::*;
();

    // One header per cycle in which valid is high, no back-pressure
    logic      valid;
    ipv4_hdr_t hdr;
    logic      ttl_expired;
    logic      csum_ok;

    // TTL updater owns the strobe and the rewritten header
    modport update_mp (output valid, output hdr, output ttl_expired);

    // Verifier only reports the checksum result
    modport verify_mp (output csum_ok);

    modport decide_mp (input valid, input hdr, input ttl_expired, input csum_ok);

endinterface

`default_nettype wire

/* rtl/ipv4_checksum_verify.sv */
////////////////////
// Two-stage IPv4 header checksum check, csum_ok lines up with the updater output
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_verify
    import ipv4_fwd_pkg::*;
(
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  ipv4_hdr_t              in_hdr,
    ipv4_stage_if.verify_mp        stage
);

    // Five words per half, 5 * 0xffff fits in 19 bits
    localparam int HALF_WORDS = IPV4_HDR_WORDS / 2;

    logic [18:0] sum_a_d;
    logic [18:0] sum_b_d;
    logic [18:0] sum_a_q;
    logic [18:0] sum_b_q;
    logic [19:0] total;
    logic [16:0] fold_1;
    csum_t       fold_2;

    ////////////////////
    // Stage one, partial sums with carries kept

    always_comb begin
        sum_a_d = '0;
        sum_b_d = '0;
        for (int i = 0; i < HALF_WORDS; i++) begin
            sum_a_d = sum_a_d + 19'(in_hdr.words[i]);
            sum_b_d = sum_b_d + 19'(in_hdr.words[i + HALF_WORDS]);
        end
    end

    // Sums only matter on strobe cycles, hold them otherwise
    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            sum_a_q <= sum_a_d;
            sum_b_q <= sum_b_d;
        end
    end

    ////////////////////
    // Stage two, end-around carry fold

    always_comb begin
        total  = 20'(sum_a_q) + 20'(sum_b_q);
        fold_1 = 17'(total[15:0]) + 17'(total[19:16]);
        // Second fold cannot carry again
        fold_2 = fold_1[15:0] + 16'(fold_1[16]);
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            stage.csum_ok <= 1'b0;
        end else begin
            stage.csum_ok <= (fold_2 == 16'hffff);
        end
    end

endmodule

`default_nettype wire

/* rtl/ipv4_ttl_update.sv */
////////////////////
// Two-stage TTL decrement with incremental checksum update (RFC 1624 eqn 3)
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_update
    import ipv4_fwd_pkg::*;
(
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  ipv4_hdr_t              in_hdr,
    ipv4_stage_if.update_mp        stage
);

    ipv4_hdr_fields_t in_f;
    logic [7:0]       new_ttl;
    logic [15:0]      old_word;
    logic [15:0]      new_word;
    logic [17:0]      delta_sum;

    logic             s1_valid;
    logic             s1_expired;
    ipv4_hdr_t        s1_hdr;
    logic [7:0]       s1_ttl;
    logic [17:0]      s1_sum;

    logic [16:0]      fold_1;
    csum_t            fold_2;
    ipv4_hdr_t        upd_hdr;

    ////////////////////
    // Stage one

    assign in_f = in_hdr.fields;

    always_comb begin
        new_ttl  = in_f.ttl - 8'd1;
        old_word = {in_f.ttl, in_f.protocol};
        new_word = {new_ttl, in_f.protocol};
        // ~HC + ~m + m' with carries folded in stage two
        delta_sum = 18'(csum_t'(~in_f.hdr_chk)) + 18'(csum_t'(~old_word)) + 18'(new_word);
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_expired <= 1'b0;
        end else begin
            s1_valid   <= in_valid;
            s1_expired <= (in_f.ttl <= 8'd1);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        s1_hdr <= in_hdr;
        s1_ttl <= new_ttl;
        s1_sum <= delta_sum;
    end

    ////////////////////
    // Stage two

    always_comb begin
        fold_1 = 17'(s1_sum[15:0]) + 17'(s1_sum[17:16]);
        fold_2 = fold_1[15:0] + 16'(fold_1[16]);
        upd_hdr = s1_hdr;
        upd_hdr.fields.ttl     = s1_ttl;
        upd_hdr.fields.hdr_chk = ~fold_2;
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            stage.valid       <= 1'b0;
            stage.ttl_expired <= 1'b0;
        end else begin
            stage.valid       <= s1_valid;
            stage.ttl_expired <= s1_expired;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        stage.hdr <= upd_hdr;
    end

endmodule

`default_nettype wire

/* rtl/ipv4_fwd_decision.sv */
////////////////////
// Final register stage, forwards or drops each header and counts both outcomes
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_fwd_decision
    import ipv4_fwd_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    ipv4_stage_if.decide_mp        stage,
    output logic                   out_valid,
    output ipv4_hdr_t              out_hdr,
    output logic                   drop_valid,
    output logic                   drop_csum,
    output logic [COUNT_WIDTH-1:0] fwd_count,
    output logic [COUNT_WIDTH-1:0] drop_count
);

    logic fwd_now;
    logic drop_now;

    // Bad checksum wins over an expired TTL
    assign fwd_now  = stage.valid && stage.csum_ok && !stage.ttl_expired;
    assign drop_now = stage.valid && !fwd_now;

    ////////////////////
    // Strobes and counters

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            drop_valid <= 1'b0;
            drop_csum  <= 1'b0;
            fwd_count  <= '0;
            drop_count <= '0;
        end else begin
            out_valid  <= fwd_now;
            drop_valid <= drop_now;
            drop_csum  <= drop_now && !stage.csum_ok;
            // Counters wrap at full scale
            if (fwd_now) begin
                fwd_count <= fwd_count + 1'b1;
            end
            if (drop_now) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Last forwarded header stays on out_hdr
    always_ff @(posedge core_clk_ifc) begin
        if (fwd_now) begin
            out_hdr <= stage.hdr;
        end
    end

endmodule

`default_nettype wire

/* rtl/ipv4_ttl_fwd.sv */
////////////////////
// IPv4 TTL forwarding stage top, one header per cycle in, result 3 cycles later
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_fwd
    import ipv4_fwd_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  ipv4_hdr_t              in_hdr,
    output logic                   out_valid,
    output ipv4_hdr_t              out_hdr,
    output logic                   drop_valid,
    output logic                   drop_csum,
    output logic [COUNT_WIDTH-1:0] fwd_count,
    output logic [COUNT_WIDTH-1:0] drop_count
);

    ipv4_stage_if u_stage_if ();

    // Both header blocks sample the same strobe and finish together
    ipv4_checksum_verify u_checksum_verify (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hdr       (in_hdr),
        .stage        (u_stage_if)
    );

    ipv4_ttl_update u_ttl_update (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hdr       (in_hdr),
        .stage        (u_stage_if)
    );

    ipv4_fwd_decision #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_fwd_decision (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .stage        (u_stage_if),
        .out_valid    (out_valid),
        .out_hdr      (out_hdr),
        .drop_valid   (drop_valid),
        .drop_csum    (drop_csum),
        .fwd_count    (fwd_count),
        .drop_count   (drop_count)
    );

endmodule

`default_nettype wire

/* tests/ipv4_ttl_fwd_props.sv */
////////////////////
// Output strobe properties bound into the forwarding stage top
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_fwd_props
    import ipv4_fwd_pkg::*;
(
    input logic      core_clk_ifc,
    input logic      rst_n,
    input logic      in_valid,
    input logic      out_valid,
    input logic      drop_valid,
    input ipv4_hdr_t out_hdr
);

    // Each strobe gives exactly one outcome
    a_one_outcome: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        in_valid |-> ##3 (out_valid != drop_valid))
        else $error("input strobe without exactly one outcome 3 cycles later");

    ////////////////////
    // Three-cycle latency

    a_fwd_latency: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without an input strobe 3 cycles earlier");

    a_drop_latency: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        drop_valid |-> $past(in_valid, 3))
        else $error("drop_valid without an input strobe 3 cycles earlier");

    // TTL 0 must be dropped so 255 never leaves
    a_no_underflow: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_valid |-> (out_hdr.fields.ttl != 8'hff))
        else $error("forwarded header has TTL 255 from underflow");

endmodule

bind ipv4_ttl_fwd ipv4_ttl_fwd_props u_props (
    .core_clk_ifc (core_clk_ifc),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .drop_valid   (drop_valid),
    .out_hdr      (out_hdr)
);

`default_nettype wire

/* tests/ipv4_ttl_fwd_tb.sv */
////////////////////
// Table-driven testbench for the IPv4 TTL forwarding stage
// Each result is compared with a full checksum recomputation
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_fwd_tb
    import ipv4_fwd_pkg::*;
();

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_TESTS     = 12;
    localparam int SEED          = 50;
    localparam int WATCHDOG_NS   = (NUM_TESTS + RESET_CYCLES + 20) * CLK_PERIOD_NS * 2;
    // Result shows on the fourth falling edge after the driving edge
    localparam int LATENCY_NEG   = 4;
    localparam int VAL_W         = IPV4_HDR_BITS;

    typedef struct packed {
        logic [7:0] ttl;
        logic       corrupt;
        logic [3:0] gap;
    } stim_t;

    typedef struct packed {
        int        idx;
        int        due;
        logic      drop;
        logic      csum_bad;
        ipv4_hdr_t hdr;
    } expect_t;

    logic        core_clk_ifc;
    logic        rst_n;
    logic        in_valid;
    ipv4_hdr_t   in_hdr;
    logic        out_valid;
    ipv4_hdr_t   out_hdr;
    logic        drop_valid;
    logic        drop_csum;
    logic [15:0] fwd_count;
    logic [15:0] drop_count;

    ////////////////////
    // Stimulus table of TTL, corrupt checksum flag and idle cycles before

    stim_t stim_table [NUM_TESTS] = '{
        '{8'd64,  1'b0, 4'd2},
        '{8'd2,   1'b0, 4'd1},
        '{8'd1,   1'b0, 4'd1},
        '{8'd0,   1'b0, 4'd1},
        '{8'd64,  1'b1, 4'd1},
        '{8'd1,   1'b1, 4'd1},
        '{8'd255, 1'b0, 4'd2},
        // Back-to-back run
        '{8'd128, 1'b0, 4'd0},
        '{8'd0,   1'b0, 4'd0},
        '{8'd33,  1'b1, 4'd0},
        '{8'd3,   1'b0, 4'd0},
        '{8'd17,  1'b0, 4'd0}
    };

    expect_t exp_q [$];
    int      neg_cnt       = 0;
    int      error_count   = 0;
    int      fwd_expected  = 0;
    int      drop_expected = 0;

    ipv4_ttl_fwd #(
        .COUNT_WIDTH (16)
    ) u_ipv4_ttl_fwd (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_hdr       (in_hdr),
        .out_valid    (out_valid),
        .out_hdr      (out_hdr),
        .drop_valid   (drop_valid),
        .drop_csum    (drop_csum),
        .fwd_count    (fwd_count),
        .drop_count   (drop_count)
    );

    initial core_clk_ifc = 1'b0;
    always #(CLK_PERIOD_NS / 2) core_clk_ifc = ~core_clk_ifc;

    ////////////////////
    // Reference model and checks

    // Full ones'-complement sum over the header with the checksum field zeroed
    function automatic csum_t header_checksum(input ipv4_hdr_t hdr);
        ipv4_hdr_t   tmp;
        logic [31:0] acc;
        tmp = hdr;
        tmp.fields.hdr_chk = '0;
        acc = '0;
        for (int i = 0; i < IPV4_HDR_WORDS; i++) begin
            acc = acc + 32'(tmp.words[i]);
        end
        while (acc[31:16] != 16'd0) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        return ~acc[15:0];
    endfunction

    function automatic ipv4_hdr_t build_hdr(input logic [7:0] ttl);
        ipv4_hdr_t hdr;
        hdr.fields.version    = 4'd4;
        hdr.fields.ihl        = 4'd5;
        hdr.fields.tos        = 8'h00;
        hdr.fields.total_len  = 16'd84;
        hdr.fields.ident      = 16'($urandom());
        hdr.fields.flags_frag = 16'h4000;
        hdr.fields.ttl        = ttl;
        hdr.fields.protocol   = 8'd17;
        hdr.fields.hdr_chk    = '0;
        hdr.fields.src_addr   = $urandom();
        hdr.fields.dst_addr   = $urandom();
        hdr.fields.hdr_chk    = header_checksum(hdr);
        return hdr;
    endfunction

    task automatic check_value(input string name, input logic [VAL_W-1:0] actual,
                               input logic [VAL_W-1:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic score_result();
        expect_t cur;
        int      errs_before;
        string   kind;
        cur = exp_q.pop_front();
        errs_before = error_count;
        check_value("out_valid", VAL_W'(out_valid), VAL_W'(!cur.drop));
        check_value("drop_valid", VAL_W'(drop_valid), VAL_W'(cur.drop));
        if (cur.drop) begin
            check_value("drop_csum", VAL_W'(drop_csum), VAL_W'(cur.csum_bad));
            kind = cur.csum_bad ? "drop, bad checksum" : "drop, TTL expired";
        end else begin
            check_value("out_hdr", out_hdr, cur.hdr);
            kind = "forward";
        end
        $display("Test %0d (%s): %s", cur.idx, kind,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    // Outputs are sampled on the falling edge away from the DUT's updates
    always @(negedge core_clk_ifc) begin
        neg_cnt = neg_cnt + 1;
        if (rst_n) begin
            if (exp_q.size() > 0 && exp_q[0].due == neg_cnt) begin
                score_result();
            end else begin
                check_value("out_valid", VAL_W'(out_valid), '0);
                check_value("drop_valid", VAL_W'(drop_valid), '0);
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        ipv4_hdr_t hdr;
        expect_t   item;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_hdr   = '0;
        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        rst_n <= 1'b1;

        @(negedge core_clk_ifc);
        check_value("out_valid", VAL_W'(out_valid), '0);
        check_value("drop_valid", VAL_W'(drop_valid), '0);
        check_value("fwd_count", VAL_W'(fwd_count), '0);
        check_value("drop_count", VAL_W'(drop_count), '0);

        for (int i = 0; i < NUM_TESTS; i++) begin
            repeat (stim_table[i].gap) begin
                @(posedge core_clk_ifc);
                in_valid <= 1'b0;
            end
            hdr = build_hdr(stim_table[i].ttl);
            item.idx      = i;
            item.csum_bad = stim_table[i].corrupt;
            item.drop     = stim_table[i].corrupt || (stim_table[i].ttl <= 8'd1);
            // Forwarded header gets TTL minus one and a fresh checksum
            item.hdr                = hdr;
            item.hdr.fields.ttl     = hdr.fields.ttl - 8'd1;
            item.hdr.fields.hdr_chk = header_checksum(item.hdr);
            if (stim_table[i].corrupt) begin
                hdr.fields.hdr_chk[0] = ~hdr.fields.hdr_chk[0];
            end
            if (item.drop) begin
                drop_expected++;
            end else begin
                fwd_expected++;
            end
            @(posedge core_clk_ifc);
            in_valid <= 1'b1;
            in_hdr   <= hdr;
            item.due = neg_cnt + LATENCY_NEG;
            exp_q.push_back(item);
        end
        @(posedge core_clk_ifc);
        in_valid <= 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge core_clk_ifc);
        end
        @(posedge core_clk_ifc);
        check_value("fwd_count", VAL_W'(fwd_count), VAL_W'(fwd_expected));
        check_value("drop_count", VAL_W'(drop_count), VAL_W'(drop_expected));

        $display("Summary: %0d tests, %0d forwarded, %0d dropped, %0d errors",
                 NUM_TESTS, fwd_expected, drop_expected, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: %0d results still outstanding after %0d ns",
                 exp_q.size(), WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* ipv4_ttl_fwd.f */
rtl/ipv4_fwd_pkg.sv
rtl/ipv4_stage_if.sv
rtl/ipv4_checksum_verify.sv
rtl/ipv4_ttl_update.sv
rtl/ipv4_fwd_decision.sv
rtl/ipv4_ttl_fwd.sv
tests/ipv4_ttl_fwd_props.sv
tests/ipv4_ttl_fwd_tb.sv

/* Makefile */
# Verilator build and run for the IPv4 TTL forwarding stage

TOP = ipv4_ttl_fwd_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): ipv4_ttl_fwd.f $(wildcard rtl/*.sv tests/*.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f ipv4_ttl_fwd.f

# Pass only if the log holds the pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f ipv4_ttl_fwd.f

clean:
	rm -rf obj_dir $(LOG)
